// ==== tb.f ====
verilog/host_pkg.sv
verilog/mem_pkg.sv
verilog/pipe_in_fifo.sv
verilog/pipe_out_fifo.sv
verilog/ddr2_test.sv
verilog/burst_ram.sv
verilog/ramtest_top.sv
testbench/tb_ramtest.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_ramtest
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

# The run fails unless the log holds the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_ramtest.sv ====
// Testbench for the memory test top level
// Clock and reset, random data table, phase table applied in a loop,
// value checks and a closing report
`timescale 1ns/1ps

module tb_ramtest;

  localparam int TIMEOUT    = 1000;
  localparam int QUIET      = 100;
  localparam int FILL_WORDS = host_pkg::PIPE_IN_DEPTH * host_pkg::HOST_PER_BUF;
  localparam int NUM_PHASES = 7;
  // Host words held by the whole memory, two per memory word
  localparam int MODEL_SIZE = mem_pkg::MEM_DEPTH * 2;

  typedef struct packed {
    host_pkg::host_ctrl_t ctrl;
    int                   n_write;
    int                   n_read;
    int                   pause;
    logic                 compare;
  } phase_t;

  logic                 ti_clk;
  logic                 arst_n;
  host_pkg::host_ctrl_t ctrl;
  logic                 pipe_in_write;
  host_pkg::host_word_t pipe_in_data;
  logic                 pipe_out_read;
  logic                 pipe_in_full;
  host_pkg::host_word_t pipe_out_data;
  logic                 pipe_out_empty;

  phase_t               phases    [NUM_PHASES];
  string                names     [NUM_PHASES] = '{"fill", "drain", "round trip", "stall",
                                                   "soft reset", "refill", "readback"};
  host_pkg::host_word_t data_tab  [128];
  host_pkg::host_word_t mem_model [MODEL_SIZE];
  int data_idx;
  int wr_pos;
  int rd_pos;
  int checks;
  int errors;

  ramtest_top u_ramtest_top (
    .ti_clk         (ti_clk),
    .arst_n         (arst_n),
    .ctrl           (ctrl),
    .pipe_in_write  (pipe_in_write),
    .pipe_in_data   (pipe_in_data),
    .pipe_out_read  (pipe_out_read),
    .pipe_in_full   (pipe_in_full),
    .pipe_out_data  (pipe_out_data),
    .pipe_out_empty (pipe_out_empty)
  );

  always #2 ti_clk = ~ti_clk;

  // --------------------------------------------------------------------------
  // Checks and host-side helpers, all entered and left on a falling edge
  // --------------------------------------------------------------------------
  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic write_words(input int n);
    for (int k = 0; k < n; k++) begin
      check_value("pipe_in_full before a write", pipe_in_full, 1'b0);
      pipe_in_write = 1'b1;
      pipe_in_data  = data_tab[data_idx];
      mem_model[wr_pos] = data_tab[data_idx];
      data_idx++;
      wr_pos = (wr_pos + 1) % MODEL_SIZE;
      @(negedge ti_clk);
    end
    pipe_in_write = 1'b0;
  endtask

  task automatic wait_drained(output bit ok);
    int cycles;
    cycles = 0;
    ok = 1'b1;
    while (pipe_in_full || u_ramtest_top.in_count != '0) begin
      @(negedge ti_clk);
      cycles++;
      if (cycles == TIMEOUT) begin
        $display("timeout at %0t ns: the pipe-in buffer was never drained", $time);
        ok = 1'b0;
        return;
      end
    end
  endtask

  task automatic read_words(input int n, input logic compare, output bit ok);
    int cycles;
    ok = 1'b1;
    for (int k = 0; k < n; k++) begin
      cycles = 0;
      while (pipe_out_empty) begin
        pipe_out_read = 1'b0;
        @(negedge ti_clk);
        cycles++;
        if (cycles == TIMEOUT) begin
          $display("timeout at %0t ns: pipe-out offered no word for read %0d", $time, k);
          ok = 1'b0;
          return;
        end
      end
      if (compare)
        check_value($sformatf("pipe_out word %0d", rd_pos), pipe_out_data,
                    mem_model[rd_pos]);
      rd_pos = (rd_pos + 1) % MODEL_SIZE;
      pipe_out_read = 1'b1;
      @(negedge ti_clk);
    end
    pipe_out_read = 1'b0;
  endtask

  task automatic check_quiet();
    for (int c = 0; c < QUIET && pipe_out_empty; c++)
      @(negedge ti_clk);
    check_value("pipe_out_empty while reads are off", pipe_out_empty, 1'b1);
  endtask

  task automatic run_phase(input phase_t ph, output bit ok);
    ok = 1'b1;
    ctrl = ph.ctrl;
    write_words(ph.n_write);
    if (!ph.ctrl.writes_en && ph.n_write > 0)
      check_value("pipe_in_full after the writes", pipe_in_full, ph.n_write == FILL_WORDS);
    if (ph.ctrl.writes_en) begin
      wait_drained(ok);
      if (!ok)
        return;
    end
    repeat (ph.pause) @(negedge ti_clk);
    if (ph.ctrl.soft_reset) begin
      // Both burst addresses restart at zero
      wr_pos = 0;
      rd_pos = 0;
      check_value("pipe_out_empty in soft reset", pipe_out_empty, 1'b1);
      check_value("pipe_in_full in soft reset", pipe_in_full, 1'b0);
    end
    read_words(ph.n_read, ph.compare, ok);
    if (!ok)
      return;
    if (!ph.ctrl.reads_en)
      check_quiet();
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    bit ok;
    int err_before;
    ti_clk        = 1'b0;
    arst_n        = 1'b0;
    ctrl          = '0;
    pipe_in_write = 1'b0;
    pipe_in_data  = '0;
    pipe_out_read = 1'b0;
    data_idx = 0;
    wr_pos   = 0;
    rd_pos   = 0;
    checks   = 0;
    errors   = 0;
    void'($urandom(32'h676a142e));
    foreach (data_tab[i])
      data_tab[i] = host_pkg::host_word_t'($urandom);

    // ctrl {reads_en, writes_en, soft_reset}, words in, words out, pause, compare
    phases[0] = '{3'b000, FILL_WORDS, 0, 0, 1'b1};
    phases[1] = '{3'b010, 0, 0, 0, 1'b1};
    phases[2] = '{3'b100, 0, FILL_WORDS, 0, 1'b1};
    // Host stops popping until the pipe-out buffer backs up
    phases[3] = '{3'b100, 0, 8, 200, 1'b0};
    phases[4] = '{3'b001, 0, 0, 4, 1'b0};
    phases[5] = '{3'b010, 16, 0, 0, 1'b1};
    phases[6] = '{3'b100, 0, 16, 0, 1'b1};

    repeat (16) @(posedge ti_clk);
    @(negedge ti_clk);
    arst_n = 1'b1;
    @(negedge ti_clk);
    check_value("pipe_out_empty after reset", pipe_out_empty, 1'b1);
    check_value("pipe_in_full after reset", pipe_in_full, 1'b0);
    $display("test reset finished with %0d errors", errors);

    ok = 1'b1;
    for (int i = 0; i < NUM_PHASES && ok; i++) begin
      err_before = errors;
      run_phase(phases[i], ok);
      if (!ok)
        errors++;
      $display("test %0d %s finished with %0d errors", i, names[i], errors - err_before);
    end
    ctrl = '0;

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== verilog/ramtest_top.sv ====
// Top level of the memory test
// Pipe-in buffer, test engine, burst memory and pipe-out buffer
`timescale 1ns/1ps

module ramtest_top (
  input  logic                 ti_clk,
  input  logic                 arst_n,
  input  host_pkg::host_ctrl_t ctrl,
  input  logic                 pipe_in_write,
  input  host_pkg::host_word_t pipe_in_data,
  input  logic                 pipe_out_read,
  output logic                 pipe_in_full,
  output host_pkg::host_word_t pipe_out_data,
  output logic                 pipe_out_empty
);

  host_pkg::buf_word_t  in_data;
  host_pkg::buf_count_t in_count;
  logic                 in_read;
  host_pkg::buf_word_t  out_data;
  host_pkg::buf_count_t out_count;
  logic                 out_write;
  logic                 cmd_en;
  mem_pkg::mem_cmd_t    cmd;
  logic                 cmd_full;
  logic                 wr_en;
  mem_pkg::mem_word_t   wr_data;
  logic                 rd_en;
  mem_pkg::mem_word_t   rd_data;
  logic                 rd_empty;

  pipe_in_fifo u_pipe_in_fifo (
    .ti_clk        (ti_clk),
    .arst_n        (arst_n),
    .soft_reset    (ctrl.soft_reset),
    .pipe_in_write (pipe_in_write),
    .pipe_in_data  (pipe_in_data),
    .in_read       (in_read),
    .pipe_in_full  (pipe_in_full),
    .in_data       (in_data),
    .in_count      (in_count)
  );

  pipe_out_fifo u_pipe_out_fifo (
    .ti_clk         (ti_clk),
    .arst_n         (arst_n),
    .soft_reset     (ctrl.soft_reset),
    .out_write      (out_write),
    .out_data       (out_data),
    .pipe_out_read  (pipe_out_read),
    .out_count      (out_count),
    .pipe_out_data  (pipe_out_data),
    .pipe_out_empty (pipe_out_empty)
  );

  ddr2_test u_ddr2_test (
    .ti_clk    (ti_clk),
    .arst_n    (arst_n),
    .ctrl      (ctrl),
    .in_data   (in_data),
    .in_count  (in_count),
    .out_count (out_count),
    .cmd_full  (cmd_full),
    .rd_data   (rd_data),
    .rd_empty  (rd_empty),
    .in_read   (in_read),
    .out_write (out_write),
    .out_data  (out_data),
    .cmd_en    (cmd_en),
    .cmd       (cmd),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .rd_en     (rd_en)
  );

  burst_ram u_burst_ram (
    .ti_clk   (ti_clk),
    .arst_n   (arst_n),
    .cmd_en   (cmd_en),
    .cmd      (cmd),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_en    (rd_en),
    .cmd_full (cmd_full),
    .rd_data  (rd_data),
    .rd_empty (rd_empty)
  );

endmodule

// ==== verilog/burst_ram.sv ====
// On-chip burst memory
// Word array with a write data queue and a read data queue, serving one
// burst command at a time at one word per cycle
`timescale 1ns/1ps

module burst_ram (
  input  logic               ti_clk,
  input  logic               arst_n,
  input  logic               cmd_en,
  input  mem_pkg::mem_cmd_t  cmd,
  input  logic               wr_en,
  input  mem_pkg::mem_word_t wr_data,
  input  logic               rd_en,
  output logic               cmd_full,
  output mem_pkg::mem_word_t rd_data,
  output logic               rd_empty
);

  mem_pkg::mem_word_t ram [mem_pkg::MEM_DEPTH];
  mem_pkg::mem_word_t wq  [mem_pkg::BURST_WORDS];
  mem_pkg::mem_word_t rq  [mem_pkg::BURST_WORDS];
  logic [$clog2(mem_pkg::BURST_WORDS)-1:0] wq_wr_q;
  logic [$clog2(mem_pkg::BURST_WORDS)-1:0] wq_rd_q;
  logic [$clog2(mem_pkg::BURST_WORDS)-1:0] rq_wr_q;
  logic [$clog2(mem_pkg::BURST_WORDS)-1:0] rq_rd_q;
  logic [$clog2(mem_pkg::BURST_WORDS):0]   wq_count_q;
  logic [$clog2(mem_pkg::BURST_WORDS):0]   rq_count_q;
  mem_pkg::mem_instr_e instr_q;
  mem_pkg::mem_addr_t  addr_q;
  mem_pkg::burst_len_t left_q;
  logic busy_q;
  logic wq_pop;
  logic rq_push;
  logic rq_pop;

  assign cmd_full = busy_q;
  assign wq_pop   = busy_q && (instr_q == mem_pkg::MEM_WRITE);
  assign rq_push  = busy_q && (instr_q == mem_pkg::MEM_READ);
  assign rq_pop   = rd_en && !rd_empty;
  assign rd_empty = (rq_count_q == '0);
  assign rd_data  = rq[rq_rd_q];

  always_ff @(posedge ti_clk) begin
    if (wr_en)
      wq[wq_wr_q] <= wr_data;
    if (wq_pop)
      ram[addr_q] <= wq[wq_rd_q];
    if (rq_push)
      rq[rq_wr_q] <= ram[addr_q];
  end

  // --------------------------------------------------------------------------
  // Burst execution and queue pointers
  // --------------------------------------------------------------------------
  always_ff @(posedge ti_clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q     <= 1'b0;
      instr_q    <= mem_pkg::MEM_WRITE;
      addr_q     <= '0;
      left_q     <= '0;
      wq_wr_q    <= '0;
      wq_rd_q    <= '0;
      rq_wr_q    <= '0;
      rq_rd_q    <= '0;
      wq_count_q <= '0;
      rq_count_q <= '0;
    end else begin
      if (cmd_en && !busy_q) begin
        busy_q  <= 1'b1;
        instr_q <= cmd.instr;
        addr_q  <= cmd.addr;
        left_q  <= cmd.bl;
      end else if (busy_q) begin
        addr_q <= addr_q + 1'b1;
        left_q <= left_q - 1'b1;
        if (left_q == mem_pkg::burst_len_t'(1))
          busy_q <= 1'b0;
      end
      if (wr_en)
        wq_wr_q <= wq_wr_q + 1'b1;
      if (wq_pop)
        wq_rd_q <= wq_rd_q + 1'b1;
      if (wr_en && !wq_pop)
        wq_count_q <= wq_count_q + 1'b1;
      else if (wq_pop && !wr_en)
        wq_count_q <= wq_count_q - 1'b1;
      if (rq_push)
        rq_wr_q <= rq_wr_q + 1'b1;
      if (rq_pop)
        rq_rd_q <= rq_rd_q + 1'b1;
      if (rq_push && !rq_pop)
        rq_count_q <= rq_count_q + 1'b1;
      else if (rq_pop && !rq_push)
        rq_count_q <= rq_count_q - 1'b1;
    end
  end

  // Write data for a burst is complete before its command
  a_wr_cmd_full_queue: assert property (@(posedge ti_clk) disable iff (!arst_n)
    (cmd_en && cmd.instr == mem_pkg::MEM_WRITE) |-> int'(wq_count_q) == int'(cmd.bl));

  // Reader drains fast enough that a fill never overruns the queue
  a_rq_no_overflow: assert property (@(posedge ti_clk) disable iff (!arst_n)
    (rq_push && !rq_pop) |-> int'(rq_count_q) < mem_pkg::BURST_WORDS);

endmodule

// ==== verilog/ddr2_test.sv ====
// Test engine
// Moves buffered entries to the memory port in write bursts and brings
// them back in read bursts, two memory words per entry, low half first
`timescale 1ns/1ps

module ddr2_test (
  input  logic                 ti_clk,
  input  logic                 arst_n,
  input  host_pkg::host_ctrl_t ctrl,
  input  host_pkg::buf_word_t  in_data,
  input  host_pkg::buf_count_t in_count,
  input  host_pkg::buf_count_t out_count,
  input  logic                 cmd_full,
  input  mem_pkg::mem_word_t   rd_data,
  input  logic                 rd_empty,
  output logic                 in_read,
  output logic                 out_write,
  output host_pkg::buf_word_t  out_data,
  output logic                 cmd_en,
  output mem_pkg::mem_cmd_t    cmd,
  output logic                 wr_en,
  output mem_pkg::mem_word_t   wr_data,
  output logic                 rd_en
);

  mem_pkg::test_state_e state_q;
  mem_pkg::test_state_e state_d;
  mem_pkg::mem_addr_t   wr_addr_q;
  mem_pkg::mem_addr_t   rd_addr_q;
  mem_pkg::mem_word_t   lo_q;
  logic [$clog2(mem_pkg::BURST_WORDS)-1:0] word_q;
  host_pkg::buf_count_t out_free;
  logic last_word;
  logic wr_go;
  logic rd_go;

  assign out_free  = host_pkg::buf_count_t'(host_pkg::PIPE_OUT_DEPTH) - out_count;
  assign wr_go     = ctrl.writes_en &&
                     (in_count >= host_pkg::buf_count_t'(mem_pkg::BURST_BUF));
  assign rd_go     = ctrl.reads_en &&
                     (out_free >= host_pkg::buf_count_t'(mem_pkg::BURST_BUF));
  assign last_word = (int'(word_q) == mem_pkg::BURST_WORDS - 1);

  // Odd words carry the upper half of an entry
  assign wr_data  = word_q[0] ? mem_pkg::mem_word_t'(in_data >> $bits(mem_pkg::mem_word_t))
                              : mem_pkg::mem_word_t'(in_data);
  assign out_data = {rd_data, lo_q};

  assign cmd.instr = (state_q == mem_pkg::ST_WR_CMD) ? mem_pkg::MEM_WRITE : mem_pkg::MEM_READ;
  assign cmd.addr  = (state_q == mem_pkg::ST_WR_CMD) ? wr_addr_q : rd_addr_q;
  assign cmd.bl    = mem_pkg::burst_len_t'(mem_pkg::BURST_WORDS);

  // --------------------------------------------------------------------------
  // Next state and strobes
  // --------------------------------------------------------------------------
  always_comb begin
    state_d   = state_q;
    in_read   = 1'b0;
    wr_en     = 1'b0;
    cmd_en    = 1'b0;
    rd_en     = 1'b0;
    out_write = 1'b0;
    case (state_q)
      mem_pkg::ST_IDLE: begin
        // Writes win when both are ready
        if (wr_go)
          state_d = mem_pkg::ST_WR_DATA;
        else if (rd_go)
          state_d = mem_pkg::ST_RD_CMD;
      end
      mem_pkg::ST_WR_DATA: begin
        wr_en   = 1'b1;
        in_read = word_q[0];
        if (last_word)
          state_d = mem_pkg::ST_WR_CMD;
      end
      mem_pkg::ST_WR_CMD: begin
        if (!cmd_full) begin
          cmd_en  = 1'b1;
          state_d = mem_pkg::ST_IDLE;
        end
      end
      mem_pkg::ST_RD_CMD: begin
        if (!cmd_full) begin
          cmd_en  = 1'b1;
          state_d = mem_pkg::ST_RD_DATA;
        end
      end
      mem_pkg::ST_RD_DATA: begin
        rd_en     = !rd_empty;
        out_write = !rd_empty && word_q[0];
        if (!rd_empty && last_word)
          state_d = mem_pkg::ST_IDLE;
      end
      default: state_d = mem_pkg::ST_IDLE;
    endcase
    if (ctrl.soft_reset) begin
      in_read   = 1'b0;
      wr_en     = 1'b0;
      cmd_en    = 1'b0;
      rd_en     = 1'b0;
      out_write = 1'b0;
      state_d   = mem_pkg::ST_IDLE;
    end
  end

  // --------------------------------------------------------------------------
  // State, word counter and burst addresses
  // --------------------------------------------------------------------------
  always_ff @(posedge ti_clk or negedge arst_n) begin
    if (!arst_n || ctrl.soft_reset) begin
      state_q   <= mem_pkg::ST_IDLE;
      word_q    <= '0;
      wr_addr_q <= '0;
      rd_addr_q <= '0;
    end else begin
      state_q <= state_d;
      // Wraps back to zero at the end of each burst
      if (wr_en || rd_en)
        word_q <= word_q + 1'b1;
      if (cmd_en && state_q == mem_pkg::ST_WR_CMD)
        wr_addr_q <= wr_addr_q + mem_pkg::mem_addr_t'(mem_pkg::BURST_WORDS);
      if (cmd_en && state_q == mem_pkg::ST_RD_CMD)
        rd_addr_q <= rd_addr_q + mem_pkg::mem_addr_t'(mem_pkg::BURST_WORDS);
    end
  end

  // Low half waits for its partner word
  always_ff @(posedge ti_clk) begin
    if (rd_en && !word_q[0])
      lo_q <= rd_data;
  end

  // Command only into an idle memory, which then reports busy
  a_cmd_not_full: assert property (@(posedge ti_clk) disable iff (!arst_n)
    cmd_en |-> !cmd_full ##1 cmd_full);

endmodule

// ==== verilog/pipe_out_fifo.sv ====
// Pipe-out buffer
// Stores 64-bit entries and hands the head entry to the host as 16-bit
// words, low word first, first-word fall-through
`timescale 1ns/1ps

module pipe_out_fifo (
  input  logic                 ti_clk,
  input  logic                 arst_n,
  input  logic                 soft_reset,
  input  logic                 out_write,
  input  host_pkg::buf_word_t  out_data,
  input  logic                 pipe_out_read,
  output host_pkg::buf_count_t out_count,
  output host_pkg::host_word_t pipe_out_data,
  output logic                 pipe_out_empty
);

  host_pkg::buf_word_t store [host_pkg::PIPE_OUT_DEPTH];
  host_pkg::buf_word_t head;
  logic [$clog2(host_pkg::HOST_PER_BUF)-1:0]   lane_q;
  logic [$clog2(host_pkg::PIPE_OUT_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(host_pkg::PIPE_OUT_DEPTH)-1:0] rd_ptr_q;
  logic full;
  logic push;
  logic take;
  logic pop;

  assign full = (out_count == host_pkg::buf_count_t'(host_pkg::PIPE_OUT_DEPTH));
  assign pipe_out_empty = (out_count == '0);
  assign push = out_write && !full && !soft_reset;
  assign take = pipe_out_read && !pipe_out_empty && !soft_reset;
  // Entry is freed with its last word
  assign pop  = take && (int'(lane_q) == host_pkg::HOST_PER_BUF - 1);

  assign head = store[rd_ptr_q];
  assign pipe_out_data =
    head[lane_q*$bits(host_pkg::host_word_t) +: $bits(host_pkg::host_word_t)];

  always_ff @(posedge ti_clk) begin
    if (push)
      store[wr_ptr_q] <= out_data;
  end

  always_ff @(posedge ti_clk or negedge arst_n) begin
    if (!arst_n || soft_reset) begin
      lane_q    <= '0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      out_count <= '0;
    end else begin
      if (take)
        lane_q <= lane_q + 1'b1;
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop)
        out_count <= out_count + 1'b1;
      else if (pop && !push)
        out_count <= out_count - 1'b1;
    end
  end

  // Test engine keeps its own room count and never overfills
  a_no_write_full: assert property (@(posedge ti_clk) disable iff (!arst_n)
    out_write |-> !full);

endmodule

// ==== verilog/pipe_in_fifo.sv ====
// Pipe-in buffer
// Packs 16-bit host words into 64-bit entries, low word first, and holds
// them in a first-word fall-through store
`timescale 1ns/1ps

module pipe_in_fifo (
  input  logic                 ti_clk,
  input  logic                 arst_n,
  input  logic                 soft_reset,
  input  logic                 pipe_in_write,
  input  host_pkg::host_word_t pipe_in_data,
  input  logic                 in_read,
  output logic                 pipe_in_full,
  output host_pkg::buf_word_t  in_data,
  output host_pkg::buf_count_t in_count
);

  host_pkg::buf_word_t store [host_pkg::PIPE_IN_DEPTH];
  host_pkg::buf_word_t stage_q;
  host_pkg::buf_word_t entry;
  logic [$clog2(host_pkg::HOST_PER_BUF)-1:0]  lane_q;
  logic [$clog2(host_pkg::PIPE_IN_DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(host_pkg::PIPE_IN_DEPTH)-1:0] rd_ptr_q;
  logic accept;
  logic push;
  logic pop;

  assign pipe_in_full = (in_count == host_pkg::buf_count_t'(host_pkg::PIPE_IN_DEPTH));
  assign accept = pipe_in_write && !pipe_in_full && !soft_reset;
  assign push   = accept && (int'(lane_q) == host_pkg::HOST_PER_BUF - 1);
  assign pop    = in_read && (in_count != '0) && !soft_reset;
  assign in_data = store[rd_ptr_q];

  // Newest word goes into its lane of the staged entry
  always_comb begin
    entry = stage_q;
    entry[lane_q*$bits(host_pkg::host_word_t) +: $bits(host_pkg::host_word_t)] = pipe_in_data;
  end

  always_ff @(posedge ti_clk) begin
    if (accept)
      stage_q <= entry;
    if (push)
      store[wr_ptr_q] <= entry;
  end

  always_ff @(posedge ti_clk or negedge arst_n) begin
    if (!arst_n || soft_reset) begin
      lane_q   <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      in_count <= '0;
    end else begin
      if (accept)
        lane_q <= lane_q + 1'b1;
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop)
        in_count <= in_count + 1'b1;
      else if (pop && !push)
        in_count <= in_count - 1'b1;
    end
  end

  // Push never lands on an entry still held
  a_no_push_full: assert property (@(posedge ti_clk) disable iff (!arst_n)
    push |-> (in_count == '0) || (wr_ptr_q != rd_ptr_q));

  // Test engine pops only counted entries
  a_no_pop_empty: assert property (@(posedge ti_clk) disable iff (!arst_n)
    in_read |-> in_count != '0);

endmodule

// ==== verilog/mem_pkg.sv ====
// Memory-port definitions
// Word and address types, burst sizes, command struct, instruction and
// test engine state encodings

package mem_pkg;

  localparam int MEM_DEPTH   = 256;
  localparam int BURST_WORDS = 8;
  // Buffer entries per burst, two memory words each
  localparam int BURST_BUF   = 4;

  typedef logic [31:0] mem_word_t;
  // Word address, byte bits dropped
  typedef logic [7:0]  mem_addr_t;
  typedef logic [3:0]  burst_len_t;

  typedef enum logic [2:0] {
    MEM_WRITE = 3'b000,
    MEM_READ  = 3'b001
  } mem_instr_e;

  typedef struct packed {
    mem_instr_e instr;
    mem_addr_t  addr;
    burst_len_t bl;
  } mem_cmd_t;

  typedef enum logic [2:0] {
    ST_IDLE, ST_WR_DATA, ST_WR_CMD, ST_RD_CMD, ST_RD_DATA
  } test_state_e;

endpackage

// ==== verilog/host_pkg.sv ====
// Host-side definitions
// Pipe word and buffer entry types, buffer depths, control register bits

package host_pkg;

  // Host words per 64-bit buffer entry
  localparam int HOST_PER_BUF   = 4;
  localparam int PIPE_IN_DEPTH  = 16;
  localparam int PIPE_OUT_DEPTH = 16;

  typedef logic [15:0] host_word_t;
  // First host word sits in the low bits
  typedef logic [63:0] buf_word_t;
  // Entry count, reaches the full depth
  typedef logic [4:0]  buf_count_t;

  // Wire-in control bits
  typedef struct packed {
    logic reads_en;
    logic writes_en;
    logic soft_reset;
  } host_ctrl_t;

endpackage
